/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = xmi_ni_tb
FILELIST = list.f
PASS_MSG = TEST RESULT: PASS
BIN      = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* dv/xmi_ni_properties.sv */
// Network interface assertions
`include "munoc_macros.svh"

module xmi_ni_properties
	import munoc_pkg::*;
(
	input logic    clk,
	input logic    rst_n,
	input link_t   sfni_link,
	input logic    sfni_ready,
	input logic    rlxqready,
	input logic    sbni_ready,
	input logic    rlxyvalid,
	input logic    rlxyready,
	input logic    rlxywreply,
	input resp_t   rlxyresp,
	input data_t   rlxyrdata,
	input burden_t rlxyburden
);

	timeunit 1ns;
	timeprecision 1ps;

	// A stalled phit keeps its value
	phit_hold: assert property (@(posedge clk) disable iff (!rst_n)
		sfni_link[`BW_LINK-1] && !sfni_ready |=> $stable(sfni_link))
		else $error("forward phit changed while sfni_ready was low");

	// The tail closes the packet, so the link rests for a cycle after it
	tail_close: assert property (@(posedge clk) disable iff (!rst_n)
		sfni_link[`BW_LINK-1] && sfni_link[`BW_LINK-2] && sfni_ready |=>
		!sfni_link[`BW_LINK-1])
		else $error("forward phit offered right after a tail phit");

	reply_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rlxyvalid && !rlxyready |=>
		rlxyvalid && $stable({rlxywreply, rlxyresp, rlxyrdata, rlxyburden}))
		else $error("reply dropped or changed before rlxyready");

	// One edge after a reset edge every valid and ready is low
	reset_quiet: assert property (@(posedge clk)
		!rst_n |=> !sfni_link[`BW_LINK-1] && !rlxyvalid && !rlxqready && !sbni_ready)
		else $error("handshake output high during reset");

endmodule

bind xmi_master_network_interface xmi_ni_properties i_xmi_ni_properties (.*);

/* dv/xmi_ni_tb.sv */
// Master network interface testbench
`include "munoc_macros.svh"

module xmi_ni_tb
	import munoc_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 20;
	localparam int NUM_ROWS = 12;
	// Two passes over the table, the comm_disable pair and reset
	localparam int WATCHDOG_CYCLES = (2 * NUM_ROWS + 4) * 200 + 16;

	typedef struct packed {
		logic write;
		addr_t addr;
		strb_t strb;
		data_t data;
		burden_t burden;
		resp_t resp;
	} row_t;

	logic clk;
	logic rst_n;
	logic comm_disable;
	logic rlxqvalid;
	logic rlxqready;
	logic rlxqwrite;
	addr_t rlxqaddr;
	strb_t rlxqwstrb;
	data_t rlxqwdata;
	burden_t rlxqburden;
	logic rlxyvalid;
	logic rlxyready;
	logic rlxywreply;
	resp_t rlxyresp;
	data_t rlxyrdata;
	burden_t rlxyburden;
	link_t sfni_link;
	logic sfni_ready;
	link_t sbni_link;
	logic sbni_ready;

	// Write, address, strobe, data, burden, expected response
	row_t rows [NUM_ROWS] = '{
		'{1'b1, 32'h0000_0004, 4'hf, 32'h1234_5678, 4'h1, 2'd0},
		'{1'b0, 32'h0000_0004, 4'h0, 32'h0000_0000, 4'h2, 2'd0},
		'{1'b1, 32'h0000_0008, 4'h5, 32'haabb_ccdd, 4'h3, 2'd0},
		'{1'b0, 32'h0000_0008, 4'h0, 32'h0000_0000, 4'h4, 2'd0},
		'{1'b1, 32'h8000_0010, 4'hf, 32'hdead_beef, 4'h5, 2'd2},
		'{1'b0, 32'h8000_0010, 4'h0, 32'h0000_0000, 4'h6, 2'd2},
		'{1'b0, 32'h0000_0010, 4'h0, 32'h0000_0000, 4'h7, 2'd0},
		'{1'b1, 32'h0000_003c, 4'h8, 32'h9900_0000, 4'h8, 2'd0},
		'{1'b0, 32'h0000_003c, 4'h0, 32'h0000_0000, 4'h9, 2'd0},
		'{1'b1, 32'h0000_0004, 4'h2, 32'h0000_ee00, 4'ha, 2'd0},
		'{1'b0, 32'h0000_0004, 4'h0, 32'h0000_0000, 4'hb, 2'd0},
		'{1'b0, 32'h0000_0000, 4'h0, 32'h0000_0000, 4'hf, 2'd0}
	};

	// Slave memory and the expected copy of it
	data_t net_mem [16];
	data_t ref_mem [16];
	logic q_write [$];
	addr_t q_addr [$];
	strb_t q_strb [$];
	data_t q_data [$];
	burden_t q_burden [$];
	integer seed = 13612;
	int fail_count = 0;
	logic stall_en;

	xmi_master_network_interface i_xmi_master_network_interface (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic data_t fill_word(input int idx);
		return 32'h5a00_0000 | (32'(idx) * 32'h0001_0203);
	endfunction

	function automatic logic draw_ready();
		return stall_en ? (($random(seed) & 3) != 0) : 1'b1;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			fail_count++;
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// ************************************************************
	// Master side
	// ************************************************************
	task automatic send_request(input row_t r);
		rlxqvalid = 1'b1;
		rlxqwrite = r.write;
		rlxqaddr = r.addr;
		rlxqwstrb = r.strb;
		rlxqwdata = r.data;
		rlxqburden = r.burden;
		@(negedge clk);
		while (!rlxqready)
			@(negedge clk);
		@(posedge clk);
		#2;
		rlxqvalid = 1'b0;
	endtask

	task automatic finish_row(input row_t r, input string name);
		logic wreply;
		resp_t resp;
		data_t rdata;
		burden_t burden;
		data_t expected;
		logic [3:0] idx;
		idx = r.addr[5:2];
		expected = ref_mem[idx];
		if (r.write && !r.addr[31]) begin
			for (int k = 0; k < `BW_STRB; k++)
				if (r.strb[k])
					ref_mem[idx][8*k +: 8] = r.data[8*k +: 8];
		end
		rlxyready = draw_ready();
		@(negedge clk);
		while (!(rlxyvalid && rlxyready)) begin
			@(posedge clk);
			#2;
			rlxyready = draw_ready();
			@(negedge clk);
		end
		wreply = rlxywreply;
		resp = rlxyresp;
		rdata = rlxyrdata;
		burden = rlxyburden;
		@(posedge clk);
		#2;
		rlxyready = 1'b0;
		check_value({name, " wreply"}, 32'(r.write), 32'(wreply));
		check_value({name, " resp"}, 32'(r.resp), 32'(resp));
		check_value({name, " burden"}, 32'(r.burden), 32'(burden));
		if (!r.write && r.resp == 2'd0)
			check_value({name, " rdata"}, expected, rdata);
	endtask

	task automatic apply_row(input row_t r, input string name);
		send_request(r);
		finish_row(r, name);
	endtask

	task automatic hold_comm_disable();
		row_t r;
		r = '{1'b1, 32'h0000_0014, 4'hf, 32'h0bad_cafe, 4'hc, 2'd0};
		comm_disable = 1'b1;
		send_request(r);
		// Request waits in the adapter, the link stays silent
		for (int c = 0; c < 50; c++) begin
			@(negedge clk);
			check_value("comm_disable link valid", 32'd0, 32'(sfni_link[`BW_LINK-1]));
			check_value("comm_disable reply valid", 32'd0, 32'(rlxyvalid));
		end
		@(posedge clk);
		#2;
		comm_disable = 1'b0;
		finish_row(r, "comm_disable write");
		r = '{1'b0, 32'h0000_0014, 4'h0, 32'h0000_0000, 4'hd, 2'd0};
		apply_row(r, "comm_disable readback");
	endtask

	// ************************************************************
	// Network slave, forward collector and backward responder
	// ************************************************************
	initial begin
		phit_t pkt [10];
		int count;
		int length;
		sfni_ready = 1'b0;
		count = 0;
		forever begin
			@(posedge clk);
			#2;
			sfni_ready = draw_ready();
			@(negedge clk);
			if (sfni_link[`BW_LINK-1] && sfni_ready) begin
				if (count < 10)
					pkt[count] = sfni_link[`BW_PHIT-1:0];
				count++;
				if (sfni_link[`BW_LINK-2]) begin
					length = pkt[0][`HDR_WRITE_BIT] ? 10 : 5;
					check_value("forward packet length", 32'(length), 32'(count));
					q_write.push_back(pkt[0][`HDR_WRITE_BIT]);
					q_burden.push_back(pkt[0][`BW_BURDEN-1:0]);
					q_addr.push_back({pkt[1], pkt[2], pkt[3], pkt[4]});
					q_strb.push_back(pkt[5][`BW_STRB-1:0]);
					q_data.push_back({pkt[6], pkt[7], pkt[8], pkt[9]});
					count = 0;
				end
			end
		end
	end

	initial begin
		logic wr;
		addr_t addr;
		strb_t strb;
		data_t data;
		burden_t burden;
		resp_t resp;
		logic [3:0] idx;
		phit_t reply [5];
		int len;
		sbni_link = '0;
		@(posedge clk);
		#2;
		forever begin
			while (q_write.size() == 0) begin
				@(posedge clk);
				#2;
			end
			wr = q_write.pop_front();
			addr = q_addr.pop_front();
			strb = q_strb.pop_front();
			data = q_data.pop_front();
			burden = q_burden.pop_front();
			idx = addr[5:2];
			// Upper half of the address space answers SLVERR
			resp = addr[31] ? 2'd2 : 2'd0;
			if (wr && !addr[31]) begin
				for (int k = 0; k < `BW_STRB; k++)
					if (strb[k])
						net_mem[idx][8*k +: 8] = data[8*k +: 8];
			end
			reply[0] = '0;
			reply[0][`HDR_WRITE_BIT] = wr;
			reply[0][`HDR_RESP_LSB +: `BW_RESP] = resp;
			reply[0][`BW_BURDEN-1:0] = burden;
			{reply[1], reply[2], reply[3], reply[4]} = net_mem[idx];
			len = wr ? 1 : 5;
			for (int k = 0; k < len; k++) begin
				sbni_link = {1'b1, k == len - 1, reply[k]};
				@(negedge clk);
				while (!sbni_ready)
					@(negedge clk);
				@(posedge clk);
				#2;
			end
			sbni_link = '0;
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before all rows completed");
		$display("TEST RESULT: FAIL");
		$fatal(1, "timeout");
	end

	initial begin
		rst_n = 1'b0;
		comm_disable = 1'b0;
		rlxqvalid = 1'b0;
		rlxqwrite = 1'b0;
		rlxqaddr = '0;
		rlxqwstrb = '0;
		rlxqwdata = '0;
		rlxqburden = '0;
		rlxyready = 1'b0;
		stall_en = 1'b0;
		for (int i = 0; i < 16; i++) begin
			net_mem[i] = fill_word(i);
			ref_mem[i] = fill_word(i);
		end
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
		for (int pass = 0; pass < 2; pass++) begin
			// Second pass adds random stalls on both ready signals
			stall_en = (pass == 1);
			for (int i = 0; i < NUM_ROWS; i++)
				apply_row(rows[i], $sformatf("pass %0d row %0d", pass, i));
		end
		hold_comm_disable();
		if (fail_count == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("TEST RESULT: FAIL");
			$fatal(1, "checks failed");
		end
	end

endmodule

/* list.f */
+incdir+source
source/munoc_pkg.sv
source/xmi_axi_adapter.sv
source/fni_packetizer.sv
source/bni_depacketizer.sv
source/xmi_master_network_interface.sv
dv/xmi_ni_properties.sv
dv/xmi_ni_tb.sv

/* source/bni_depacketizer.sv */
// Backward link depacketizer
`include "munoc_macros.svh"

module bni_depacketizer
	import munoc_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  link_t   sbni_link,
	output logic    sbni_ready,
	output logic    bvalid,
	input  logic    bready,
	output burden_t bid,
	output resp_t   bresp,
	output logic    rvalid,
	input  logic    rready,
	output burden_t rid,
	output data_t   rdata,
	output resp_t   rresp
);

	dpk_state_e state;
	dpk_state_e state_d;
	logic link_valid;
	logic link_tail;
	phit_t phit;
	logic take;
	logic beat_done;
	logic reply_write;
	resp_t reply_resp;
	burden_t reply_burden;
	data_t reply_data;

	assign link_valid = sbni_link[`BW_LINK-1];
	assign link_tail = sbni_link[`BW_LINK-2];
	assign phit = sbni_link[`BW_PHIT-1:0];
	assign take = link_valid && sbni_ready;
	assign beat_done = (bvalid && bready) || (rvalid && rready);

	always_comb begin
		state_d = state;
		case (state)
			dpk_header: if (take) state_d = link_tail ? dpk_deliver : dpk_data;
			dpk_data: if (take && link_tail) state_d = dpk_deliver;
			dpk_deliver: if (beat_done) state_d = dpk_header;
			default: state_d = dpk_header;
		endcase
	end

	// Link stays blocked while a finished beat waits
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= dpk_header;
			sbni_ready <= 1'b0;
		end else begin
			state <= state_d;
			sbni_ready <= (state_d != dpk_deliver);
		end
	end

	always_ff @(posedge clk) begin
		if (take && state == dpk_header) begin
			reply_write <= phit[`HDR_WRITE_BIT];
			reply_resp <= phit[`HDR_RESP_LSB +: `BW_RESP];
			reply_burden <= phit[`BW_BURDEN-1:0];
		end
		// Read data arrives most significant phit first
		if (take && state == dpk_data)
			reply_data <= {reply_data[`BW_DATA-`BW_PHIT-1:0], phit};
	end

	assign bvalid = (state == dpk_deliver) && reply_write;
	assign rvalid = (state == dpk_deliver) && !reply_write;
	assign bid = reply_burden;
	assign rid = reply_burden;
	assign bresp = reply_resp;
	assign rresp = reply_resp;
	assign rdata = reply_data;

endmodule

/* source/fni_packetizer.sv */
// Forward link packetizer
`include "munoc_macros.svh"

module fni_packetizer
	import munoc_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    comm_disable,
	input  logic    awvalid,
	output logic    awready,
	input  addr_t   awaddr,
	input  burden_t awid,
	input  logic    wvalid,
	output logic    wready,
	input  data_t   wdata,
	input  strb_t   wstrb,
	input  logic    arvalid,
	output logic    arready,
	input  addr_t   araddr,
	input  burden_t arid,
	output link_t   sfni_link,
	input  logic    sfni_ready
);

	localparam int NUM_PHITS = 10;
	localparam int BW_SHIFT = NUM_PHITS * `BW_PHIT;

	pkt_state_e state;
	logic [BW_SHIFT-1:0] shift_q;
	logic [3:0] remain;
	logic pkt_write;
	logic prio_write;
	logic write_req;
	logic pick_write;
	logic start;
	logic busy;
	logic phit_sent;
	phit_t header;

	// ************************************************************
	// Arbitration, write needs both AW and W
	// ************************************************************
	assign write_req = awvalid && wvalid;
	assign pick_write = write_req && (prio_write || !arvalid);
	assign start = (state == pkt_idle) && !comm_disable && (write_req || arvalid);
	assign awready = start && pick_write;
	assign wready = start && pick_write;
	assign arready = start && !pick_write;

	always_comb begin
		header = '0;
		header[`HDR_WRITE_BIT] = pick_write;
		header[`BW_BURDEN-1:0] = pick_write ? awid : arid;
	end

	// Link output, phits leave from the top of the shift register
	assign busy = (state != pkt_idle);
	assign phit_sent = busy && sfni_ready;
	assign sfni_link = {busy, busy && (remain == 4'd0), shift_q[BW_SHIFT-1 -: `BW_PHIT]};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= pkt_idle;
			remain <= '0;
			pkt_write <= 1'b0;
			prio_write <= 1'b1;
		end else if (start) begin
			state <= pkt_header;
			remain <= pick_write ? 4'd9 : 4'd4;
			pkt_write <= pick_write;
			prio_write <= !pick_write;
		end else if (phit_sent) begin
			remain <= remain - 4'd1;
			case (state)
				pkt_header: state <= pkt_address;
				pkt_address: begin
					if (remain == 4'd0)
						state <= pkt_idle;
					else if (pkt_write && remain == 4'd5)
						state <= pkt_strobe;
				end
				pkt_strobe: state <= pkt_data;
				pkt_data: begin
					if (remain == 4'd0)
						state <= pkt_idle;
				end
				default: state <= pkt_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			if (pick_write)
				shift_q <= {header, awaddr, {(`BW_PHIT-`BW_STRB){1'b0}}, wstrb, wdata};
			else
				shift_q <= {header, araddr, {(BW_SHIFT-`BW_PHIT-`BW_ADDR){1'b0}}};
		end else if (phit_sent) begin
			shift_q <= shift_q << `BW_PHIT;
		end
	end

endmodule

/* source/munoc_macros.svh */
// Network interface widths
`ifndef MUNOC_MACROS_SVH
`define MUNOC_MACROS_SVH

// Master port and AXI-style channel widths
`define BW_ADDR 32
`define BW_DATA 32
`define BW_STRB 4
`define BW_BURDEN 4
`define BW_RESP 2

// Link phit, plus tail and valid bits on top
`define BW_PHIT 8
`define BW_LINK 10

// ************************************************************
// Header phit layout
// Request header: write bit, burden in the low bits
// Reply header: write-reply bit, response, burden
// ************************************************************
`define HDR_WRITE_BIT 7
`define HDR_RESP_LSB 4

`endif

/* source/munoc_pkg.sv */
// Network interface types
`include "munoc_macros.svh"

package munoc_pkg;

	typedef logic [`BW_ADDR-1:0] addr_t;
	typedef logic [`BW_DATA-1:0] data_t;
	typedef logic [`BW_STRB-1:0] strb_t;
	typedef logic [`BW_BURDEN-1:0] burden_t;
	typedef logic [`BW_PHIT-1:0] phit_t;
	typedef logic [`BW_LINK-1:0] link_t;
	typedef logic [`BW_RESP-1:0] resp_t;

	// Forward packet serializer
	typedef enum logic [2:0] {
		pkt_idle,
		pkt_header,
		pkt_address,
		pkt_strobe,
		pkt_data
	} pkt_state_e;

	// Backward packet collector
	typedef enum logic [1:0] {
		dpk_header,
		dpk_data,
		dpk_deliver
	} dpk_state_e;

endpackage

/* source/xmi_axi_adapter.sv */
// Request to AXI channel adapter
`include "munoc_macros.svh"

module xmi_axi_adapter
	import munoc_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    rlxqvalid,
	output logic    rlxqready,
	input  logic    rlxqwrite,
	input  addr_t   rlxqaddr,
	input  strb_t   rlxqwstrb,
	input  data_t   rlxqwdata,
	input  burden_t rlxqburden,
	output logic    rlxyvalid,
	input  logic    rlxyready,
	output logic    rlxywreply,
	output resp_t   rlxyresp,
	output data_t   rlxyrdata,
	output burden_t rlxyburden,
	output logic    awvalid,
	input  logic    awready,
	output addr_t   awaddr,
	output burden_t awid,
	output logic    wvalid,
	input  logic    wready,
	output data_t   wdata,
	output strb_t   wstrb,
	output logic    arvalid,
	input  logic    arready,
	output addr_t   araddr,
	output burden_t arid,
	input  logic    bvalid,
	output logic    bready,
	input  burden_t bid,
	input  resp_t   bresp,
	input  logic    rvalid,
	output logic    rready,
	input  burden_t rid,
	input  data_t   rdata,
	input  resp_t   rresp
);

	addr_t req_addr;
	burden_t req_burden;
	logic req_take;
	logic chan_free;
	logic b_take;
	logic r_take;

	// ************************************************************
	// Request side
	// ************************************************************
	assign req_take = rlxqvalid && rlxqready;
	assign chan_free = (!awvalid || awready) && (!wvalid || wready) && (!arvalid || arready);

	// Address and tag are shared, only one channel set is ever loaded
	assign awaddr = req_addr;
	assign araddr = req_addr;
	assign awid = req_burden;
	assign arid = req_burden;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rlxqready <= 1'b0;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			arvalid <= 1'b0;
		end else begin
			if (awvalid && awready)
				awvalid <= 1'b0;
			if (wvalid && wready)
				wvalid <= 1'b0;
			if (arvalid && arready)
				arvalid <= 1'b0;
			if (req_take) begin
				awvalid <= rlxqwrite;
				wvalid <= rlxqwrite;
				arvalid <= !rlxqwrite;
			end
			// Ready answers a waiting request once all channels have drained
			rlxqready <= rlxqvalid && !req_take && chan_free;
		end
	end

	always_ff @(posedge clk) begin
		if (req_take) begin
			req_addr <= rlxqaddr;
			req_burden <= rlxqburden;
			wdata <= rlxqwdata;
			wstrb <= rlxqwstrb;
		end
	end

	// ************************************************************
	// Reply side, B wins over R
	// ************************************************************
	assign bready = !rlxyvalid;
	assign rready = !rlxyvalid && !bvalid;
	assign b_take = bvalid && bready;
	assign r_take = rvalid && rready;

	always_ff @(posedge clk) begin
		if (!rst_n)
			rlxyvalid <= 1'b0;
		else if (b_take || r_take)
			rlxyvalid <= 1'b1;
		else if (rlxyready)
			rlxyvalid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (b_take) begin
			rlxywreply <= 1'b1;
			rlxyresp <= bresp;
			rlxyburden <= bid;
		end else if (r_take) begin
			rlxywreply <= 1'b0;
			rlxyresp <= rresp;
			rlxyburden <= rid;
			rlxyrdata <= rdata;
		end
	end

endmodule

/* source/xmi_master_network_interface.sv */
// Master network interface top
`include "munoc_macros.svh"

module xmi_master_network_interface
	import munoc_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    comm_disable,
	input  logic    rlxqvalid,
	output logic    rlxqready,
	input  logic    rlxqwrite,
	input  addr_t   rlxqaddr,
	input  strb_t   rlxqwstrb,
	input  data_t   rlxqwdata,
	input  burden_t rlxqburden,
	output logic    rlxyvalid,
	input  logic    rlxyready,
	output logic    rlxywreply,
	output resp_t   rlxyresp,
	output data_t   rlxyrdata,
	output burden_t rlxyburden,
	output link_t   sfni_link,
	input  logic    sfni_ready,
	input  link_t   sbni_link,
	output logic    sbni_ready
);

	// ************************************************************
	// AXI-style channels between the blocks
	// ************************************************************
	logic awvalid, awready, wvalid, wready, arvalid, arready;
	logic bvalid, bready, rvalid, rready;
	addr_t awaddr, araddr;
	burden_t awid, arid, bid, rid;
	data_t wdata, rdata;
	strb_t wstrb;
	resp_t bresp, rresp;

	xmi_axi_adapter i_xmi_axi_adapter (.*);

	fni_packetizer i_fni_packetizer (.*);

	bni_depacketizer i_bni_depacketizer (.*);

endmodule
